/* all.f */
+incdir+verif
src/pcs_rx_pkg.sv
src/block_aligner.sv
src/block_lock_fsm.sv
src/descrambler.sv
src/block_decoder.sv
src/idle_pattern_checker.sv
src/status_regs.sv
src/pcs_rx_top.sv
verif/pcs_rx_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module pcs_rx_tb -f all.f -o Vpcs_rx_tb

# the simulator exits non-zero on a failed check, the log decides the result
./obj_dir/Vpcs_rx_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "CHECKS FAILED" sim.log; then
    echo "simulation reported a failure"
    exit 1
fi
if ! grep -q "ALL CHECKS PASSED" sim.log; then
    echo "simulation ended without a result line"
    exit 1
fi

/* src/block_aligner.sv */
// block aligner: two-word window, slip offset register and registered block select
`timescale 1ns/1ns

module block_aligner
    import pcs_rx_pkg::*;
(
    input  logic         i_clock,
    input  logic         i_reset,
    input  logic         i_valid,
    input  coded_block_t i_data,
    input  logic         i_slip,
    output logic         o_valid,
    output coded_block_t o_block
);

    coded_block_t          prev_word;
    logic [2*NB_BLOCK-1:0] window;
    logic [NB_SLIP-1:0]    slip_offset;
    logic [NB_SLIP-1:0]    sel_start;

    // earlier bits in the low half
    assign window = {i_data, prev_word};

    // offset 0 takes the current word as is, larger offsets reach back into the previous one
    assign sel_start = NB_SLIP'(NB_BLOCK) - slip_offset;

    always_ff @(posedge i_clock)
    begin
        if (i_reset)
        begin
            slip_offset <= '0;
        end
        else if (i_slip)
        begin
            if (slip_offset == NB_SLIP'(NB_BLOCK - 1))
            begin
                slip_offset <= '0;
            end
            else
            begin
                slip_offset <= slip_offset + 1'b1;
            end
        end
    end

    always_ff @(posedge i_clock)
    begin
        if (i_reset)
        begin
            o_valid <= 1'b0;
        end
        else
        begin
            o_valid <= i_valid;
        end
    end

    always_ff @(posedge i_clock)
    begin
        if (i_valid)
        begin
            prev_word <= i_data;
            o_block   <= window[sel_start +: NB_BLOCK];
        end
    end

endmodule

/* src/block_decoder.sv */
// block decoder: data, idle and start blocks to data and control words, error flag
`timescale 1ns/1ns

module block_decoder
    import pcs_rx_pkg::*;
(
    input  logic         i_clock,
    input  logic         i_reset,
    input  logic         i_valid,
    input  coded_block_t i_block,
    input  logic         i_block_lock,
    output logic         o_valid,
    output xgmii_word_t  o_word,
    output logic         o_error
);

    xgmii_word_t dec_word;
    logic        dec_error;

    always_comb
    begin
        // anything not recognised below decodes to error characters
        dec_word.data = {8{ERROR_CHAR}};
        dec_word.ctrl = '1;
        dec_error     = 1'b1;
        if (i_block.sh == SH_DATA)
        begin
            dec_word.data = i_block.payload;
            dec_word.ctrl = '0;
            dec_error     = 1'b0;
        end
        else if (i_block.sh == SH_CTRL)
        begin
            case (i_block.payload[7:0])
                BT_IDLE:
                begin
                    dec_word.data = {8{IDLE_CHAR}};
                    dec_word.ctrl = '1;
                    dec_error     = 1'b0;
                end
                BT_START:
                begin
                    // start in lane 0, type byte replaced by the start character
                    dec_word.data = {i_block.payload[NB_PAYLOAD-1:8], START_CHAR};
                    dec_word.ctrl = NB_CTRL'(1);
                    dec_error     = 1'b0;
                end
                default:
                begin
                    dec_error = 1'b1;
                end
            endcase
        end
    end

    always_ff @(posedge i_clock)
    begin
        if (i_reset)
        begin
            o_valid <= 1'b0;
            o_error <= 1'b0;
        end
        else
        begin
            o_valid <= i_valid && i_block_lock;
            o_error <= i_valid && i_block_lock && dec_error;
        end
    end

    always_ff @(posedge i_clock)
    begin
        if (i_valid)
        begin
            o_word <= dec_word;
        end
    end

endmodule

/* src/block_lock_fsm.sv */
// block lock FSM: sync header test, window and invalid-header counting, slip control
`timescale 1ns/1ns

module block_lock_fsm
    import pcs_rx_pkg::*;
(
    input  logic         i_clock,
    input  logic         i_reset,
    input  logic         i_valid,
    input  coded_block_t i_block,
    input  logic         i_signal_ok,
    input  lock_cfg_t    i_lock_cfg,
    output logic         o_slip,
    output logic         o_block_lock
);

    lock_state_t          state;
    logic [NB_WINDOW-1:0] window_count;
    logic [NB_WINDOW-1:0] invalid_count;
    logic [NB_WINDOW-1:0] next_window;
    logic [NB_WINDOW-1:0] next_invalid;
    logic [1:0]           ignore_count;
    logic                 sh_valid;

    assign sh_valid     = (i_block.sh == SH_DATA) || (i_block.sh == SH_CTRL);
    assign next_window  = window_count + 1'b1;
    assign next_invalid = invalid_count + 1'b1;

    always_ff @(posedge i_clock)
    begin
        // signal loss behaves like a reset of the lock logic
        if (i_reset || !i_signal_ok)
        begin
            state         <= LOCK_INIT;
            window_count  <= '0;
            invalid_count <= '0;
            ignore_count  <= '0;
            o_slip        <= 1'b0;
            o_block_lock  <= 1'b0;
        end
        else
        begin
            o_slip <= 1'b0;
            case (state)
                LOCK_INIT:
                begin
                    window_count  <= '0;
                    invalid_count <= '0;
                    state         <= TEST_SH;
                end
                TEST_SH:
                begin
                    if (i_valid)
                    begin
                        // skip the blocks still in flight from the old offset
                        if (ignore_count != 2'd0)
                        begin
                            ignore_count <= ignore_count - 1'b1;
                        end
                        else if (!sh_valid)
                        begin
                            o_slip       <= 1'b1;
                            ignore_count <= 2'd2;
                            window_count <= '0;
                            state        <= SLIP;
                        end
                        else if (next_window == i_lock_cfg.unlocked_window)
                        begin
                            o_block_lock  <= 1'b1;
                            window_count  <= '0;
                            invalid_count <= '0;
                            state         <= LOCKED;
                        end
                        else
                        begin
                            window_count <= next_window;
                        end
                    end
                end
                SLIP:
                begin
                    if (i_valid && ignore_count != 2'd0)
                    begin
                        ignore_count <= ignore_count - 1'b1;
                    end
                    state <= TEST_SH;
                end
                LOCKED:
                begin
                    if (i_valid)
                    begin
                        if (!sh_valid && next_invalid == i_lock_cfg.invalid_limit)
                        begin
                            o_block_lock  <= 1'b0;
                            o_slip        <= 1'b1;
                            ignore_count  <= 2'd2;
                            window_count  <= '0;
                            invalid_count <= '0;
                            state         <= SLIP;
                        end
                        else if (next_window == i_lock_cfg.locked_window)
                        begin
                            // new monitoring window
                            window_count  <= '0;
                            invalid_count <= '0;
                        end
                        else
                        begin
                            window_count <= next_window;
                            if (!sh_valid)
                            begin
                                invalid_count <= next_invalid;
                            end
                        end
                    end
                end
                default:
                begin
                    state <= LOCK_INIT;
                end
            endcase
        end
    end

endmodule

/* src/descrambler.sv */
// self-synchronous descrambler 1 + x^39 + x^58 with bypass
`timescale 1ns/1ns

module descrambler
    import pcs_rx_pkg::*;
(
    input  logic         i_clock,
    input  logic         i_reset,
    input  logic         i_valid,
    input  coded_block_t i_block,
    input  logic         i_bypass,
    output logic         o_valid,
    output coded_block_t o_block
);

    localparam int NB_HIST = 58;
    localparam int TAP_A   = 39;

    logic [NB_HIST-1:0]            history;
    logic [NB_PAYLOAD+NB_HIST-1:0] ext;
    logic [NB_PAYLOAD-1:0]         descrambled;

    // ext[NB_HIST + i] is received bit i, history holds the 58 bits before it
    assign ext         = {i_block.payload, history};
    assign descrambled = i_block.payload
                       ^ ext[NB_HIST-TAP_A +: NB_PAYLOAD]
                       ^ ext[NB_PAYLOAD-1:0];

    always_ff @(posedge i_clock)
    begin
        if (i_reset)
        begin
            o_valid <= 1'b0;
        end
        else
        begin
            o_valid <= i_valid;
        end
    end

    always_ff @(posedge i_clock)
    begin
        if (i_valid)
        begin
            // history follows the line even in bypass
            history    <= ext[NB_PAYLOAD+NB_HIST-1 -: NB_HIST];
            o_block.sh <= i_block.sh;
            o_block.payload <= i_bypass ? i_block.payload : descrambled;
        end
    end

endmodule

/* src/idle_pattern_checker.sv */
// idle test pattern checker with one-cycle mismatch pulse
`timescale 1ns/1ns

module idle_pattern_checker
    import pcs_rx_pkg::*;
(
    input  logic         i_clock,
    input  logic         i_reset,
    input  logic         i_valid,
    input  coded_block_t i_block,
    input  logic         i_idle_pattern_mode,
    output logic         o_mismatch
);

    // control header, idle type byte, all idle characters zero
    localparam coded_block_t IDLE_TEST_BLOCK = '{
        payload: {{(NB_PAYLOAD-8){1'b0}}, BT_IDLE},
        sh:      SH_CTRL
    };

    always_ff @(posedge i_clock)
    begin
        if (i_reset)
        begin
            o_mismatch <= 1'b0;
        end
        else
        begin
            o_mismatch <= i_valid && i_idle_pattern_mode && (i_block != IDLE_TEST_BLOCK);
        end
    end

endmodule

/* src/pcs_rx_pkg.sv */
// widths, sync headers, block and word structs, lock config, state and block-type enums
package pcs_rx_pkg;

    localparam int NB_BLOCK   = 66;
    localparam int NB_PAYLOAD = 64;
    localparam int NB_SH      = 2;
    localparam int NB_CTRL    = 8;
    localparam int NB_SLIP    = 7;
    localparam int NB_WINDOW  = 12;

    // header bit 0 goes on the line first
    localparam logic [NB_SH-1:0] SH_DATA = 2'b10;
    localparam logic [NB_SH-1:0] SH_CTRL = 2'b01;

    // decoded character bytes
    localparam logic [7:0] IDLE_CHAR  = 8'h07;
    localparam logic [7:0] START_CHAR = 8'hFB;
    localparam logic [7:0] ERROR_CHAR = 8'hFE;

    // sync header sits in the low bits, so bit 0 of the vector is the first bit on the line
    typedef struct packed {
        logic [NB_PAYLOAD-1:0] payload;
        logic [NB_SH-1:0]      sh;
    } coded_block_t;

    typedef struct packed {
        logic [NB_PAYLOAD-1:0] data;
        logic [NB_CTRL-1:0]    ctrl;
    } xgmii_word_t;

    typedef struct packed {
        logic [NB_WINDOW-1:0] unlocked_window;
        logic [NB_WINDOW-1:0] locked_window;
        logic [NB_WINDOW-1:0] invalid_limit;
    } lock_cfg_t;

    typedef enum logic [1:0] {
        LOCK_INIT,
        TEST_SH,
        SLIP,
        LOCKED
    } lock_state_t;

    // type byte is payload bits 7:0
    typedef enum logic [7:0] {
        BT_IDLE  = 8'h1E,
        BT_START = 8'h78
    } block_type_t;

endpackage

/* src/pcs_rx_top.sv */
// 64b/66b receive path top: aligner, lock FSM, descrambler, decoder, checker, status
`timescale 1ns/1ns

module pcs_rx_top
    import pcs_rx_pkg::*;
#(
    parameter int NB_ERR_COUNT      = 16,
    parameter int NB_MISMATCH_COUNT = 32
)
(
    input  logic                         i_clock,
    input  logic                         i_reset,
    input  logic                         i_valid,
    input  coded_block_t                 i_phy_data,
    input  logic                         i_signal_ok,
    input  lock_cfg_t                    i_lock_cfg,
    input  logic                         i_bypass,
    input  logic                         i_idle_pattern_mode,
    input  logic                         i_read_lock_lost,
    input  logic                         i_read_err_count,
    input  logic                         i_read_mismatch_count,
    output logic                         o_valid,
    output xgmii_word_t                  o_word,
    output logic                         o_block_lock,
    output logic                         o_lock_lost,
    output logic [NB_ERR_COUNT-1:0]      o_err_count,
    output logic [NB_MISMATCH_COUNT-1:0] o_mismatch_count
);

    coded_block_t aligned_block;
    logic         aligned_valid;
    coded_block_t descr_block;
    logic         descr_valid;
    logic         slip;
    logic         block_lock;
    logic         decode_error;
    logic         mismatch;

    assign o_block_lock = block_lock;

    block_aligner u_block_aligner (
        .i_clock (i_clock),
        .i_reset (i_reset),
        .i_valid (i_valid),
        .i_data  (i_phy_data),
        .i_slip  (slip),
        .o_valid (aligned_valid),
        .o_block (aligned_block)
    );

    block_lock_fsm u_block_lock_fsm (
        .i_clock      (i_clock),
        .i_reset      (i_reset),
        .i_valid      (aligned_valid),
        .i_block      (aligned_block),
        .i_signal_ok  (i_signal_ok),
        .i_lock_cfg   (i_lock_cfg),
        .o_slip       (slip),
        .o_block_lock (block_lock)
    );

    descrambler u_descrambler (
        .i_clock  (i_clock),
        .i_reset  (i_reset),
        .i_valid  (aligned_valid),
        .i_block  (aligned_block),
        .i_bypass (i_bypass),
        .o_valid  (descr_valid),
        .o_block  (descr_block)
    );

    block_decoder u_block_decoder (
        .i_clock      (i_clock),
        .i_reset      (i_reset),
        .i_valid      (descr_valid),
        .i_block      (descr_block),
        .i_block_lock (block_lock),
        .o_valid      (o_valid),
        .o_word       (o_word),
        .o_error      (decode_error)
    );

    idle_pattern_checker u_idle_pattern_checker (
        .i_clock             (i_clock),
        .i_reset             (i_reset),
        .i_valid             (descr_valid),
        .i_block             (descr_block),
        .i_idle_pattern_mode (i_idle_pattern_mode),
        .o_mismatch          (mismatch)
    );

    status_regs #(
        .NB_ERR_COUNT      (NB_ERR_COUNT),
        .NB_MISMATCH_COUNT (NB_MISMATCH_COUNT)
    ) u_status_regs (
        .i_clock               (i_clock),
        .i_reset               (i_reset),
        .i_block_lock          (block_lock),
        .i_error               (decode_error),
        .i_mismatch            (mismatch),
        .i_read_lock_lost      (i_read_lock_lost),
        .i_read_err_count      (i_read_err_count),
        .i_read_mismatch_count (i_read_mismatch_count),
        .o_lock_lost           (o_lock_lost),
        .o_err_count           (o_err_count),
        .o_mismatch_count      (o_mismatch_count)
    );

endmodule

/* src/status_regs.sv */
// clear-on-read status: lock-lost flag, errored-block and mismatch counters
`timescale 1ns/1ns

module status_regs
#(
    parameter int NB_ERR_COUNT      = 16,
    parameter int NB_MISMATCH_COUNT = 32
)
(
    input  logic                         i_clock,
    input  logic                         i_reset,
    input  logic                         i_block_lock,
    input  logic                         i_error,
    input  logic                         i_mismatch,
    input  logic                         i_read_lock_lost,
    input  logic                         i_read_err_count,
    input  logic                         i_read_mismatch_count,
    output logic                         o_lock_lost,
    output logic [NB_ERR_COUNT-1:0]      o_err_count,
    output logic [NB_MISMATCH_COUNT-1:0] o_mismatch_count
);

    logic read_lock_lost_d;
    logic read_err_count_d;
    logic read_mismatch_count_d;
    logic block_lock_d;
    logic clear_lock_lost;
    logic clear_err_count;
    logic clear_mismatch_count;

    assign clear_lock_lost      = i_read_lock_lost && !read_lock_lost_d;
    assign clear_err_count      = i_read_err_count && !read_err_count_d;
    assign clear_mismatch_count = i_read_mismatch_count && !read_mismatch_count_d;

    always_ff @(posedge i_clock)
    begin
        if (i_reset)
        begin
            read_lock_lost_d      <= 1'b0;
            read_err_count_d      <= 1'b0;
            read_mismatch_count_d <= 1'b0;
            block_lock_d          <= 1'b0;
        end
        else
        begin
            read_lock_lost_d      <= i_read_lock_lost;
            read_err_count_d      <= i_read_err_count;
            read_mismatch_count_d <= i_read_mismatch_count;
            block_lock_d          <= i_block_lock;
        end
    end

    // sticky until read, set on a falling edge of lock
    always_ff @(posedge i_clock)
    begin
        if (i_reset || clear_lock_lost)
        begin
            o_lock_lost <= 1'b0;
        end
        else if (block_lock_d && !i_block_lock)
        begin
            o_lock_lost <= 1'b1;
        end
    end

    // both counters hold at full scale
    always_ff @(posedge i_clock)
    begin
        if (i_reset || clear_err_count)
        begin
            o_err_count <= '0;
        end
        else if (i_error && o_err_count != '1)
        begin
            o_err_count <= o_err_count + 1'b1;
        end
    end

    always_ff @(posedge i_clock)
    begin
        if (i_reset || clear_mismatch_count)
        begin
            o_mismatch_count <= '0;
        end
        else if (i_mismatch && o_mismatch_count != '1)
        begin
            o_mismatch_count <= o_mismatch_count + 1'b1;
        end
    end

endmodule

/* verif/pcs_rx_tasks.svh */
// stimulus, scrambler model, block builders, expected decode, compare tasks and directed tests

task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("CHECKS FAILED");
    $fatal(1, "simulation stopped");
endtask

task automatic word_check(input xgmii_word_t got, input xgmii_word_t exp, input string what);
    if (got !== exp)
    begin
        fail_run($sformatf("[ERROR] %0t ns: %s data %h ctrl %h, expected data %h ctrl %h",
                           $time, what, got.data, got.ctrl, exp.data, exp.ctrl));
    end
endtask

task automatic count_check(input logic [NB_MISMATCH_COUNT-1:0] got,
                           input logic [NB_MISMATCH_COUNT-1:0] exp, input string what);
    if (got !== exp)
    begin
        fail_run($sformatf("[ERROR] %0t ns: %s is %0d, expected %0d", $time, what, got, exp));
    end
endtask

task automatic lock_check(input logic got, input logic exp, input string what);
    if (got !== exp)
    begin
        fail_run($sformatf("[ERROR] %0t ns: %s is %b, expected %b", $time, what, got, exp));
    end
endtask

// line scrambler 1 + x^39 + x^58, first bit first
task automatic scramble_payload(input logic [NB_PAYLOAD-1:0] plain,
                                output logic [NB_PAYLOAD-1:0] line);
    logic s;
    for (int i = 0; i < NB_PAYLOAD; i++)
    begin
        s        = plain[i] ^ scr_hist[38] ^ scr_hist[57];
        line[i]  = s;
        scr_hist = {scr_hist[56:0], s};
    end
endtask

// scramble, append to the bit stream and drive the next 66-bit line word
task automatic send_block(input coded_block_t blk);
    coded_block_t          line_blk;
    logic [NB_PAYLOAD-1:0] line_payload;
    logic [NB_BLOCK-1:0]   bits;
    logic [NB_BLOCK-1:0]   word;
    scramble_payload(blk.payload, line_payload);
    line_blk.sh      = blk.sh;
    line_blk.payload = line_payload;
    bits             = line_blk;
    for (int i = 0; i < NB_BLOCK; i++)
    begin
        line_bits.push_back(bits[i]);
    end
    for (int i = 0; i < NB_BLOCK; i++)
    begin
        word[i] = line_bits.pop_front();
    end
    @(posedge i_clock);
    #1;
    i_valid    = 1'b1;
    i_phy_data = word;
endtask

function automatic coded_block_t idle_block();
    coded_block_t blk;
    blk.sh      = SH_CTRL;
    blk.payload = {{(NB_PAYLOAD-8){1'b0}}, 8'(BT_IDLE)};
    return blk;
endfunction

function automatic coded_block_t data_block();
    coded_block_t blk;
    blk.sh      = SH_DATA;
    blk.payload = {$random(seed), $random(seed)};
    return blk;
endfunction

// control header with the given type byte and random upper bytes
function automatic coded_block_t control_block(input logic [7:0] type_byte);
    coded_block_t blk;
    blk.sh      = SH_CTRL;
    blk.payload = {56'({$random(seed), $random(seed)}), type_byte};
    return blk;
endfunction

function automatic coded_block_t invalid_block();
    coded_block_t blk;
    blk    = idle_block();
    blk.sh = 2'b00;
    return blk;
endfunction

function automatic xgmii_word_t expected_word(input coded_block_t blk);
    xgmii_word_t w;
    w.data = {8{ERROR_CHAR}};
    w.ctrl = 8'hFF;
    if (blk.sh == SH_DATA)
    begin
        w.data = blk.payload;
        w.ctrl = 8'h00;
    end
    else if (blk.sh == SH_CTRL && blk.payload[7:0] == 8'(BT_IDLE))
    begin
        w.data = {8{IDLE_CHAR}};
    end
    else if (blk.sh == SH_CTRL && blk.payload[7:0] == 8'(BT_START))
    begin
        w.data = {blk.payload[NB_PAYLOAD-1:8], START_CHAR};
        w.ctrl = 8'h01;
    end
    return w;
endfunction

task automatic send_idles(input int count);
    repeat (count) send_block(idle_block());
endtask

task automatic send_expected(input coded_block_t blk);
    exp_q.push_back(expected_word(blk));
    send_block(blk);
endtask

task automatic wait_for_lock(input int limit, input string what);
    int count;
    count = 0;
    while (!o_block_lock && count < limit)
    begin
        send_block(idle_block());
        count++;
    end
    if (!o_block_lock)
    begin
        fail_run($sformatf("block lock was not reached %s within %0d blocks", what, limit));
    end
endtask

// one read level held for two cycles, the rising edge clears the register
task automatic pulse_read(input logic lock_lost, input logic err_count, input logic mismatch);
    i_read_lock_lost      = lock_lost;
    i_read_err_count      = err_count;
    i_read_mismatch_count = mismatch;
    send_idles(2);
    i_read_lock_lost      = 1'b0;
    i_read_err_count      = 1'b0;
    i_read_mismatch_count = 1'b0;
    send_idles(3);
endtask

task automatic lock_acquisition();
    wait_for_lock(LOCK_LIMIT, "at bit offset 37");
    lock_check(o_lock_lost, 1'b0, "lock-lost flag after first lock");
    count_check(NB_MISMATCH_COUNT'(o_err_count), 0, "errored block count after lock");
endtask

task automatic decode_sequence();
    int drain;
    capture_on  = 1'b1;
    seen_marker = 1'b0;
    send_expected(control_block(8'(BT_START)));
    repeat (20) send_expected(data_block());
    repeat (4) send_expected(idle_block());
    // unknown type byte
    send_expected(control_block(8'h5A));
    repeat (4) send_expected(idle_block());
    drain = 0;
    while (exp_q.size() > 0 && drain < 20)
    begin
        send_block(idle_block());
        drain++;
    end
    if (exp_q.size() > 0)
    begin
        fail_run($sformatf("%0d decoded words did not arrive at the output", exp_q.size()));
    end
    capture_on = 1'b0;
    send_idles(2);
    count_check(NB_MISMATCH_COUNT'(o_err_count), 1, "errored block count");
endtask

task automatic lock_loss_recovery();
    int                      invalid_sent;
    logic [NB_ERR_COUNT-1:0] err_before;
    invalid_sent = 0;
    err_before   = o_err_count;
    while (o_block_lock && invalid_sent < 2 * INVALID_LIMIT)
    begin
        send_block(invalid_block());
        invalid_sent++;
    end
    if (invalid_sent < INVALID_LIMIT)
    begin
        fail_run($sformatf("lock dropped after only %0d invalid headers", invalid_sent));
    end
    send_idles(1);
    lock_check(o_block_lock, 1'b0, "block lock after invalid headers");
    lock_check(o_lock_lost, 1'b1, "lock-lost flag after lock loss");
    // the header that reaches the limit meets the decoder after lock has dropped
    count_check(NB_MISMATCH_COUNT'(o_err_count),
                NB_MISMATCH_COUNT'(err_before) + INVALID_LIMIT - 1,
                "errored block count after invalid headers");
    wait_for_lock(LOCK_LIMIT, "after lock loss");
    lock_check(o_lock_lost, 1'b1, "lock-lost flag before read");
    pulse_read(1'b1, 1'b0, 1'b0);
    lock_check(o_lock_lost, 1'b0, "lock-lost flag after read");
    pulse_read(1'b0, 1'b1, 1'b0);
    count_check(NB_MISMATCH_COUNT'(o_err_count), 0, "errored block count after read");
endtask

task automatic idle_pattern_count();
    i_idle_pattern_mode = 1'b1;
    send_idles(6);
    repeat (5)
    begin
        send_block(data_block());
        send_idles(3);
    end
    send_idles(4);
    count_check(o_mismatch_count, 5, "mismatch count");
    pulse_read(1'b0, 1'b0, 1'b1);
    count_check(o_mismatch_count, 0, "mismatch count after read");
    i_idle_pattern_mode = 1'b0;
endtask

task automatic signal_loss_recovery();
    i_signal_ok = 1'b0;
    send_idles(3);
    repeat (10)
    begin
        send_block(idle_block());
        lock_check(o_block_lock, 1'b0, "block lock during signal loss");
        lock_check(o_valid, 1'b0, "o_valid during signal loss");
    end
    i_signal_ok = 1'b1;
    wait_for_lock(LOCK_LIMIT, "after signal loss");
    send_idles(4);
    lock_check(o_valid, 1'b1, "o_valid after signal returns");
endtask

/* verif/pcs_rx_tb.sv */
// testbench top: clock, reset, DUT instance, stimulus state, output monitor, watchdog, test order
`timescale 1ns/1ns

module pcs_rx_tb
    import pcs_rx_pkg::*;
();

    localparam int NB_ERR_COUNT      = 16;
    localparam int NB_MISMATCH_COUNT = 32;
    localparam int CLOCK_PERIOD      = 8;
    localparam int RESET_CYCLES      = 10;
    localparam int BIT_OFFSET        = 37;
    localparam int INVALID_LIMIT     = 16;
    localparam int LOCK_LIMIT        = 66 * 70;
    // three lock acquisitions plus the directed traffic around them
    localparam int TEST_BLOCKS       = 3 * LOCK_LIMIT + 1000;

    logic                         i_clock;
    logic                         i_reset;
    logic                         i_valid;
    coded_block_t                 i_phy_data;
    logic                         i_signal_ok;
    lock_cfg_t                    i_lock_cfg;
    logic                         i_bypass;
    logic                         i_idle_pattern_mode;
    logic                         i_read_lock_lost;
    logic                         i_read_err_count;
    logic                         i_read_mismatch_count;
    logic                         o_valid;
    xgmii_word_t                  o_word;
    logic                         o_block_lock;
    logic                         o_lock_lost;
    logic [NB_ERR_COUNT-1:0]      o_err_count;
    logic [NB_MISMATCH_COUNT-1:0] o_mismatch_count;

    integer      seed;
    // scrambled history, bit 0 is the most recent line bit
    logic [57:0] scr_hist;
    bit          line_bits[$];
    xgmii_word_t exp_q[$];
    logic        capture_on;
    logic        seen_marker;

    `include "pcs_rx_tasks.svh"

    pcs_rx_top #(
        .NB_ERR_COUNT      (NB_ERR_COUNT),
        .NB_MISMATCH_COUNT (NB_MISMATCH_COUNT)
    ) dut (
        .i_clock               (i_clock),
        .i_reset               (i_reset),
        .i_valid               (i_valid),
        .i_phy_data            (i_phy_data),
        .i_signal_ok           (i_signal_ok),
        .i_lock_cfg            (i_lock_cfg),
        .i_bypass              (i_bypass),
        .i_idle_pattern_mode   (i_idle_pattern_mode),
        .i_read_lock_lost      (i_read_lock_lost),
        .i_read_err_count      (i_read_err_count),
        .i_read_mismatch_count (i_read_mismatch_count),
        .o_valid               (o_valid),
        .o_word                (o_word),
        .o_block_lock          (o_block_lock),
        .o_lock_lost           (o_lock_lost),
        .o_err_count           (o_err_count),
        .o_mismatch_count      (o_mismatch_count)
    );

    initial
    begin
        i_clock = 1'b0;
        forever
        begin
            #(CLOCK_PERIOD / 2) i_clock = ~i_clock;
        end
    end

    initial
    begin
        #(TEST_BLOCKS * CLOCK_PERIOD * 4);
        fail_run("timeout: the tests did not finish in the expected time");
    end

    // outputs are compared from the start marker onward, at the falling edge
    always @(negedge i_clock)
    begin
        if (capture_on && o_valid && exp_q.size() > 0)
        begin
            if (!seen_marker && o_word == exp_q[0])
            begin
                seen_marker = 1'b1;
            end
            if (seen_marker)
            begin
                word_check(o_word, exp_q.pop_front(), "decoded word");
            end
        end
    end

    initial
    begin
        seed                       = 19623;
        i_reset                    = 1'b1;
        i_valid                    = 1'b0;
        i_phy_data                 = '0;
        i_signal_ok                = 1'b1;
        i_lock_cfg.unlocked_window = 12'd64;
        i_lock_cfg.locked_window   = 12'd1024;
        i_lock_cfg.invalid_limit   = 12'd16;
        i_bypass                   = 1'b0;
        i_idle_pattern_mode        = 1'b0;
        i_read_lock_lost           = 1'b0;
        i_read_err_count           = 1'b0;
        i_read_mismatch_count      = 1'b0;
        capture_on                 = 1'b0;
        seen_marker                = 1'b0;
        scr_hist                   = 58'({$random(seed), $random(seed)});
        // junk bits in front of the first block set the line offset
        for (int i = 0; i < BIT_OFFSET; i++)
        begin
            line_bits.push_back(bit'($random(seed)));
        end
        repeat (RESET_CYCLES) @(posedge i_clock);
        #1;
        i_reset = 1'b0;

        lock_acquisition();
        decode_sequence();
        lock_loss_recovery();
        idle_pattern_count();
        signal_loss_recovery();

        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule
